// ==== hdl/aes_macros.svh ====
// AES width and round-count constants
// Block, word and byte widths, column count, round counts per key length

`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

// --------------------
// Datapath widths
`define AES_BLOCK_W      128
`define AES_WORD_W       32
`define AES_BYTE_W       8

// State columns per block, one 32-bit word each
`define AES_NUM_WORDS    4

// --------------------
// Round counts per key length
`define AES128_ROUNDS    10
`define AES256_ROUNDS    14

// Round index width, wide enough for 0 to 14
`define AES_ROUND_IDX_W  4

`endif

// ==== hdl/aes_pkg.sv ====
// Shared AES types
// State union, request struct, key-length enum, datapath command and FSM states

`default_nettype none

`include "aes_macros.svh"

package aes_pkg;

  // --------------------
  // State views

  // One column, row 0 in the most significant byte
  typedef logic [0:(`AES_WORD_W / `AES_BYTE_W) - 1][`AES_BYTE_W-1:0] aes_col_t;

  // Same 128 bits seen flat or as columns
  // Column 0 sits in the top word, FIPS-197 byte 0 is the MSB
  typedef union packed {
    logic [`AES_BLOCK_W-1:0]          block;
    aes_col_t [0:`AES_NUM_WORDS-1]    cols;
  } aes_state_u;

  // --------------------
  // Request and control encodings

  typedef enum logic {
    KEY_128 = 1'b0,
    KEY_256 = 1'b1
  } aes_keylen_e;

  // Plaintext with its key length, 129 bits
  typedef struct packed {
    aes_state_u  plaintext;
    aes_keylen_e keylen;
  } aes_req_t;

  // Command from the controller to the datapath
  typedef enum logic [2:0] {
    UPD_NONE  = 3'd0,
    UPD_INIT  = 3'd1,
    UPD_SBOX  = 3'd2,
    UPD_MAIN  = 3'd3,
    UPD_FINAL = 3'd4
  } aes_update_e;

  // Round FSM states
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    INIT  = 3'd1,
    SBOX  = 3'd2,
    MAIN  = 3'd3,
    FINAL = 3'd4,
    DONE  = 3'd5
  } aes_ctrl_e;

endpackage

`default_nettype wire

// ==== hdl/aes_sbox_word.sv ====
// Four-byte forward S-box
// Word-wide SubBytes lookup built from one constant byte table

`timescale 1ns/1ns
`default_nettype none

`include "aes_macros.svh"

module aes_sbox_word (
  input  wire  [`AES_WORD_W-1:0] in_word,
  output logic [`AES_WORD_W-1:0] out_word
);

  // --------------------
  // FIPS-197 forward table
  // Entry 0 in the leftmost byte, one table row per line
  localparam logic [0:255][`AES_BYTE_W-1:0] SBOX_TABLE = {
    64'h637c777bf26b6fc5, 64'h3001672bfed7ab76,
    64'hca82c97dfa5947f0, 64'hadd4a2af9ca472c0,
    64'hb7fd9326363ff7cc, 64'h34a5e5f171d83115,
    64'h04c723c31896059a, 64'h071280e2eb27b275,
    64'h09832c1a1b6e5aa0, 64'h523bd6b329e32f84,
    64'h53d100ed20fcb15b, 64'h6acbbe394a4c58cf,
    64'hd0efaafb434d3385, 64'h45f9027f503c9fa8,
    64'h51a3408f929d38f5, 64'hbcb6da2110fff3d2,
    64'hcd0c13ec5f974417, 64'hc4a77e3d645d1973,
    64'h60814fdc222a9088, 64'h46eeb814de5e0bdb,
    64'he0323a0a4906245c, 64'hc2d3ac629195e479,
    64'he7c8376d8dd54ea9, 64'h6c56f4ea657aae08,
    64'hba78252e1ca6b4c6, 64'he8dd741f4bbd8b8a,
    64'h703eb5664803f60e, 64'h613557b986c11d9e,
    64'he1f8981169d98e94, 64'h9b1e87e9ce5528df,
    64'h8ca1890dbfe64268, 64'h41992d0fb054bb16
  };

  // Bytes handled per word
  localparam int BYTES_PER_WORD = `AES_WORD_W / `AES_BYTE_W;

  // --------------------
  // Byte lookup

  // Plain table read, synthesizes to a ROM or LUT tree
  function automatic logic [`AES_BYTE_W-1:0] sbox_byte(input logic [`AES_BYTE_W-1:0] b);
    return SBOX_TABLE[b];
  endfunction

  // Same lookup on all four lanes in parallel
  // Byte lanes are independent, so lane order does not matter here
  always_comb
  begin
    for (int i = 0; i < BYTES_PER_WORD; i++)
    begin
      out_word[i*`AES_BYTE_W +: `AES_BYTE_W] = sbox_byte(in_word[i*`AES_BYTE_W +: `AES_BYTE_W]);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/aes_round_datapath.sv ====
// AES round datapath
// State register with init, word-serial SubBytes, main-round and final-round updates
// ShiftRows and MixColumns helpers

`timescale 1ns/1ns
`default_nettype none

`include "aes_macros.svh"

module aes_round_datapath (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire aes_pkg::aes_update_e    update,
  input  wire  [1:0]                   sword_idx,
  input  wire aes_pkg::aes_state_u     plaintext,
  input  wire aes_pkg::aes_state_u     round_key,
  output logic [`AES_WORD_W-1:0]       sbox_in,
  input  wire  [`AES_WORD_W-1:0]       sbox_out,
  output aes_pkg::aes_state_u          state
);

  // Rows per column
  localparam int NUM_ROWS = `AES_WORD_W / `AES_BYTE_W;

  // --------------------
  // GF(2^8) helpers

  // Multiply by 2, reduce by the AES polynomial
  function automatic logic [`AES_BYTE_W-1:0] xtime(input logic [`AES_BYTE_W-1:0] b);
    return {b[`AES_BYTE_W-2:0], 1'b0} ^ (8'h1b & {`AES_BYTE_W{b[`AES_BYTE_W-1]}});
  endfunction

  // Multiply by 3
  function automatic logic [`AES_BYTE_W-1:0] gm3(input logic [`AES_BYTE_W-1:0] b);
    return xtime(b) ^ b;
  endfunction

  // --------------------
  // Round transforms

  // Row r rotates left by r columns
  function automatic aes_pkg::aes_state_u shift_rows(input aes_pkg::aes_state_u s);
    aes_pkg::aes_state_u r;
    for (int c = 0; c < `AES_NUM_WORDS; c++)
    begin
      for (int w = 0; w < NUM_ROWS; w++)
      begin
        r.cols[c][w] = s.cols[(c + w) % `AES_NUM_WORDS][w];
      end
    end
    return r;
  endfunction

  // One column through the fixed 2-3-1-1 circulant matrix
  function automatic aes_pkg::aes_col_t mix_column(input aes_pkg::aes_col_t a);
    aes_pkg::aes_col_t m;
    m[0] = xtime(a[0]) ^ gm3(a[1])   ^ a[2]        ^ a[3];
    m[1] = a[0]        ^ xtime(a[1]) ^ gm3(a[2])   ^ a[3];
    m[2] = a[0]        ^ a[1]        ^ xtime(a[2]) ^ gm3(a[3]);
    m[3] = gm3(a[0])   ^ a[1]        ^ a[2]        ^ xtime(a[3]);
    return m;
  endfunction

  // --------------------
  // Registers

  aes_pkg::aes_state_u state_reg;
  aes_pkg::aes_state_u state_next;

  // Plaintext capture
  // Follows the input while no round work is commanded, so it still holds
  // the accepted block during the INIT cycle
  aes_pkg::aes_state_u pt_reg;

  // Intermediate round values
  aes_pkg::aes_state_u shifted;
  aes_pkg::aes_state_u mixed;

  always_ff @(posedge clk)
  begin
    if (update == aes_pkg::UPD_NONE)
    begin
      pt_reg <= plaintext;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_reg.block <= '0;
    end
    else if (update != aes_pkg::UPD_NONE)
    begin
      state_reg <= state_next;
    end
  end

  // --------------------
  // Update logic

  assign shifted = shift_rows(state_reg);

  // MixColumns works column by column on the shifted state
  always_comb
  begin
    for (int c = 0; c < `AES_NUM_WORDS; c++)
    begin
      mixed.cols[c] = mix_column(shifted.cols[c]);
    end
  end

  // Selected word goes out to the S-box every cycle
  assign sbox_in = state_reg.cols[sword_idx];

  always_comb
  begin
    state_next = state_reg;
    case (update)
      // Initial AddRoundKey with round key 0
      aes_pkg::UPD_INIT:
        state_next.block = pt_reg.block ^ round_key.block;
      // Only the addressed column changes
      aes_pkg::UPD_SBOX:
        state_next.cols[sword_idx] = sbox_out;
      aes_pkg::UPD_MAIN:
        state_next.block = mixed.block ^ round_key.block;
      // Last round skips MixColumns but still adds its key
      aes_pkg::UPD_FINAL:
        state_next.block = shifted.block ^ round_key.block;
      default:
        state_next = state_reg;
    endcase
  end

  assign state = state_reg;

endmodule

`default_nettype wire

// ==== hdl/aes_encipher_ctrl.sv ====
// AES round controller
// Round FSM with word and round counters, key-length latch,
// input and output valid/ready handshakes

`timescale 1ns/1ns
`default_nettype none

`include "aes_macros.svh"

module aes_encipher_ctrl (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire                          in_valid,
  output logic                         in_ready,
  input  wire aes_pkg::aes_keylen_e    keylen,
  output logic                         out_valid,
  input  wire                          out_ready,
  output aes_pkg::aes_update_e         update,
  output logic [1:0]                   sword_idx,
  output logic [`AES_ROUND_IDX_W-1:0]  round_idx
);

  aes_pkg::aes_ctrl_e               ctrl_reg;
  aes_pkg::aes_keylen_e             keylen_reg;
  logic [`AES_ROUND_IDX_W-1:0]      num_rounds;

  // Round count follows the latched key length
  assign num_rounds = (keylen_reg == aes_pkg::KEY_256) ?
                      `AES_ROUND_IDX_W'(`AES256_ROUNDS) :
                      `AES_ROUND_IDX_W'(`AES128_ROUNDS);

  // --------------------
  // FSM and counters
  // sword_idx and round_idx are the counters themselves
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      ctrl_reg   <= aes_pkg::IDLE;
      keylen_reg <= aes_pkg::KEY_128;
      sword_idx  <= '0;
      round_idx  <= '0;
      in_ready   <= 1'b1;
      out_valid  <= 1'b0;
    end
    else
    begin
      case (ctrl_reg)
        aes_pkg::IDLE:
        begin
          // Accept edge, only one block in flight
          if (in_valid && in_ready)
          begin
            keylen_reg <= keylen;
            sword_idx  <= '0;
            round_idx  <= '0;
            in_ready   <= 1'b0;
            ctrl_reg   <= aes_pkg::INIT;
          end
        end
        aes_pkg::INIT:
        begin
          // Key 0 is consumed here, round 1 starts next
          round_idx <= round_idx + 1'b1;
          ctrl_reg  <= aes_pkg::SBOX;
        end
        aes_pkg::SBOX:
        begin
          sword_idx <= sword_idx + 1'b1;
          if (sword_idx == 2'(`AES_NUM_WORDS - 1))
          begin
            // Final round decided here, datapath never looks at round numbers
            ctrl_reg <= (round_idx == num_rounds) ? aes_pkg::FINAL : aes_pkg::MAIN;
          end
        end
        aes_pkg::MAIN:
        begin
          round_idx <= round_idx + 1'b1;
          ctrl_reg  <= aes_pkg::SBOX;
        end
        aes_pkg::FINAL:
        begin
          out_valid <= 1'b1;
          ctrl_reg  <= aes_pkg::DONE;
        end
        aes_pkg::DONE:
        begin
          // Wait here under back-pressure, result held in the datapath
          if (out_ready)
          begin
            out_valid <= 1'b0;
            in_ready  <= 1'b1;
            ctrl_reg  <= aes_pkg::IDLE;
          end
        end
        default:
          ctrl_reg <= aes_pkg::IDLE;
      endcase
    end
  end

  // --------------------
  // Datapath command, one register write per busy state
  always_comb
  begin
    case (ctrl_reg)
      aes_pkg::INIT:  update = aes_pkg::UPD_INIT;
      aes_pkg::SBOX:  update = aes_pkg::UPD_SBOX;
      aes_pkg::MAIN:  update = aes_pkg::UPD_MAIN;
      aes_pkg::FINAL: update = aes_pkg::UPD_FINAL;
      default:        update = aes_pkg::UPD_NONE;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/aes_encipher_core.sv ====
// AES encipher core top level
// Controller, round datapath and word S-box
// Round keys come from an outside key store, indexed by round_idx

`timescale 1ns/1ns
`default_nettype none

`include "aes_macros.svh"

module aes_encipher_core (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire                          in_valid,
  output logic                         in_ready,
  input  wire aes_pkg::aes_req_t       in_req,
  output logic                         out_valid,
  input  wire                          out_ready,
  output aes_pkg::aes_state_u          out_block,
  output logic [`AES_ROUND_IDX_W-1:0]  round_idx,
  input  wire aes_pkg::aes_state_u     round_key
);

  // Controller to datapath
  aes_pkg::aes_update_e     update;
  logic [1:0]               sword_idx;

  // Datapath to S-box and back
  logic [`AES_WORD_W-1:0]   sbox_in;
  logic [`AES_WORD_W-1:0]   sbox_out;

  aes_encipher_ctrl u_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .keylen    (in_req.keylen),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .update    (update),
    .sword_idx (sword_idx),
    .round_idx (round_idx)
  );

  // State register drives the ciphertext port directly
  aes_round_datapath u_datapath (
    .clk       (clk),
    .reset_n   (reset_n),
    .update    (update),
    .sword_idx (sword_idx),
    .plaintext (in_req.plaintext),
    .round_key (round_key),
    .sbox_in   (sbox_in),
    .sbox_out  (sbox_out),
    .state     (out_block)
  );

  aes_sbox_word u_sbox (
    .in_word  (sbox_in),
    .out_word (sbox_out)
  );

endmodule

`default_nettype wire

// ==== dv/aes_encipher_sva.sv ====
// Handshake assertions for the AES encipher core
// Bound into the core top level from the testbench

`timescale 1ns/1ns
`default_nettype none

`include "aes_macros.svh"

module aes_encipher_sva (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire                          in_ready,
  input  wire                          out_valid,
  input  wire                          out_ready,
  input  wire aes_pkg::aes_state_u     out_block,
  input  wire [`AES_ROUND_IDX_W-1:0]   round_idx
);

  // --------------------
  // Input side only opens while no result is waiting
  a_ready_valid_excl: assert property (@(posedge clk) disable iff (!reset_n)
    !(in_ready && out_valid))
    else $error("in_ready and out_valid high in the same cycle");

  // Blocked result holds until taken
  a_out_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_block.block)))
    else $error("out_valid or out_block changed under back-pressure");

  // Key store has 15 entries
  a_round_range: assert property (@(posedge clk) disable iff (!reset_n)
    round_idx <= `AES_ROUND_IDX_W'(`AES256_ROUNDS))
    else $error("round_idx beyond the last round key");

  // Nothing to deliver right after reset
  a_reset_out: assert property (@(posedge clk)
    !reset_n |=> !out_valid)
    else $error("out_valid high after reset");

endmodule

`default_nettype wire

// ==== dv/aes_encipher_tb.sv ====
// AES encipher core testbench
// Clock, reset, LFSR stimulus, reference model, compare tasks
// Directed tests for both key lengths, back-pressure and back-to-back blocks

`timescale 1ns/1ns
`default_nettype none

`include "aes_macros.svh"

module aes_encipher_tb;

  // Cycle budget for reset, 8 AES-128 and 4 AES-256 blocks, back-pressure and 6 mixed blocks
  localparam int RUN_CYCLES     = 10 + 8 * 55 + 4 * 75 + 100 + 6 * 75;
  localparam int TIMEOUT_CYCLES = 3 * RUN_CYCLES;
  localparam logic [15:0] LFSR_SEED = 16'd10152;

  logic                          clk = 1'b0;
  logic                          reset_n;
  logic                          in_valid;
  logic                          in_ready;
  aes_pkg::aes_req_t             in_req;
  logic                          out_valid;
  logic                          out_ready;
  aes_pkg::aes_state_u           out_block;
  logic [`AES_ROUND_IDX_W-1:0]   round_idx;
  aes_pkg::aes_state_u           round_key;

  // Key store with one entry per round index
  aes_pkg::aes_state_u round_keys [0:`AES256_ROUNDS];

  logic [15:0] lfsr_state;
  int error_count = 0;
  int check_count = 0;
  int test_count  = 0;
  int fail_tests  = 0;
  int cycle_count = 0;

  always #5 clk = ~clk;

  // Combinational key store read
  assign round_key = round_keys[round_idx];

  aes_encipher_core UUT (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_block (out_block),
    .round_idx (round_idx),
    .round_key (round_key)
  );

  bind aes_encipher_core aes_encipher_sva u_sva (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_block (out_block),
    .round_idx (round_idx)
  );

  // --------------------
  // Stimulus values

  // Taps x^16 + x^14 + x^13 + x^11 with feedback into the top bit
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
  endfunction

  // One LFSR step per bit taken
  task automatic random_block(output aes_pkg::aes_state_u v);
    for (int i = 0; i < `AES_BLOCK_W; i++)
    begin
      v.block[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Arbitrary keys since expansion is not part of the core
  task automatic new_round_keys();
    aes_pkg::aes_state_u k;
    for (int r = 0; r <= `AES256_ROUNDS; r++)
    begin
      random_block(k);
      round_keys[r] = k;
    end
  endtask

  // --------------------
  // Reference model

  // Shift-and-add product in GF(2^8)
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
      if (b[i])
      begin
        p = p ^ x;
      end
      x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1b) : {x[6:0], 1'b0};
    end
    return p;
  endfunction

  // Inverse as a^254 where zero maps to zero
  function automatic logic [7:0] gf_inv(input logic [7:0] a);
    logic [7:0] r;
    logic [7:0] base;
    logic [7:0] e;
    r    = 8'h01;
    base = a;
    e    = 8'hfe;
    for (int i = 0; i < 8; i++)
    begin
      if (e[i])
      begin
        r = gf_mul(r, base);
      end
      base = gf_mul(base, base);
    end
    return r;
  endfunction

  // Inverse followed by the affine map
  function automatic logic [7:0] sbox_model(input logic [7:0] b);
    logic [7:0] v;
    v = gf_inv(b);
    return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]} ^
           {v[3:0], v[7:4]} ^ 8'h63;
  endfunction

  function automatic int rounds_for(input aes_pkg::aes_keylen_e kl);
    return (kl == aes_pkg::KEY_256) ? `AES256_ROUNDS : `AES128_ROUNDS;
  endfunction

  // One INIT cycle then five cycles per round
  function automatic int expected_latency(input aes_pkg::aes_keylen_e kl);
    return 1 + 5 * rounds_for(kl);
  endfunction

  // Byte i of the block is state[i % 4][i / 4] with byte 0 as the MSB
  function automatic aes_pkg::aes_state_u model_encipher(input aes_pkg::aes_state_u pt,
                                                         input aes_pkg::aes_keylen_e kl);
    logic [7:0] s [0:15];
    logic [7:0] t [0:15];
    aes_pkg::aes_state_u res;
    int nr;
    nr = rounds_for(kl);
    for (int i = 0; i < 16; i++)
    begin
      s[i] = pt.block[8*(15-i) +: 8] ^ round_keys[0].block[8*(15-i) +: 8];
    end
    for (int r = 1; r <= nr; r++)
    begin
      // SubBytes and ShiftRows together
      for (int c = 0; c < 4; c++)
      begin
        for (int w = 0; w < 4; w++)
        begin
          t[w + 4*c] = sbox_model(s[w + 4*((c + w) % 4)]);
        end
      end
      for (int c = 0; c < 4; c++)
      begin
        if (r < nr)
        begin
          s[4*c]   = gf_mul(t[4*c], 2) ^ gf_mul(t[4*c+1], 3) ^ t[4*c+2] ^ t[4*c+3];
          s[4*c+1] = t[4*c] ^ gf_mul(t[4*c+1], 2) ^ gf_mul(t[4*c+2], 3) ^ t[4*c+3];
          s[4*c+2] = t[4*c] ^ t[4*c+1] ^ gf_mul(t[4*c+2], 2) ^ gf_mul(t[4*c+3], 3);
          s[4*c+3] = gf_mul(t[4*c], 3) ^ t[4*c+1] ^ t[4*c+2] ^ gf_mul(t[4*c+3], 2);
        end
        else
        begin
          for (int w = 0; w < 4; w++)
          begin
            s[4*c + w] = t[4*c + w];
          end
        end
      end
      for (int i = 0; i < 16; i++)
      begin
        s[i] = s[i] ^ round_keys[r].block[8*(15-i) +: 8];
      end
    end
    for (int i = 0; i < 16; i++)
    begin
      res.block[8*(15-i) +: 8] = s[i];
    end
    return res;
  endfunction

  // --------------------
  // Compare tasks

  task automatic check_block(input string name, input aes_pkg::aes_state_u got,
                             input aes_pkg::aes_state_u exp);
    check_count++;
    if (got.block !== exp.block)
    begin
      error_count++;
      $display("[ERROR] %s: got %h, expected %h", name, got.block, exp.block);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_round(input string name, input logic [`AES_ROUND_IDX_W-1:0] got,
                             input logic [`AES_ROUND_IDX_W-1:0] exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    check_count++;
    if (got != exp)
    begin
      error_count++;
      $display("Wrong latency: out_valid rose %0d cycles after accept instead of %0d",
               got, exp);
    end
  endtask

  // --------------------
  // Handshake helpers that start and end just after a falling edge

  // Returns on the falling edge after the accept edge
  task automatic offer_request(input aes_pkg::aes_req_t req);
    in_req   = req;
    in_valid = 1'b1;
    while (!in_ready)
    begin
      @(negedge clk);
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_result(output int cycles);
    cycles = 0;
    while (!out_valid)
    begin
      @(negedge clk);
      cycles++;
    end
  endtask

  // One block with fresh keys checked against the model
  task automatic run_block(input aes_pkg::aes_keylen_e kl, input bit hold_ready);
    aes_pkg::aes_req_t req;
    aes_pkg::aes_state_u expected;
    int cycles;
    new_round_keys();
    random_block(req.plaintext);
    req.keylen = kl;
    expected = model_encipher(req.plaintext, kl);
    offer_request(req);
    wait_result(cycles);
    check_latency(cycles, expected_latency(kl));
    check_block("out_block", out_block, expected);
    check_flag("in_ready", in_ready, 1'b0);
    out_ready = 1'b1;
    @(negedge clk);
    if (!hold_ready)
    begin
      out_ready = 1'b0;
    end
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("in_ready", in_ready, 1'b1);
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before)
    begin
      $display("Test %0d %s: passed", test_count, name);
    end
    else
    begin
      fail_tests++;
      $display("Test %0d %s: failed with %0d errors", test_count, name,
               error_count - errors_before);
    end
  endtask

  // --------------------
  // Directed tests

  task automatic test_after_reset();
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("in_ready", in_ready, 1'b1);
    check_round("round_idx", round_idx, '0);
    check_block("out_block", out_block, '0);
  endtask

  task automatic test_backpressure();
    aes_pkg::aes_req_t req;
    aes_pkg::aes_req_t other;
    aes_pkg::aes_state_u expected;
    int cycles;
    new_round_keys();
    random_block(req.plaintext);
    req.keylen = aes_pkg::KEY_256;
    random_block(other.plaintext);
    other.keylen = aes_pkg::KEY_128;
    expected = model_encipher(req.plaintext, req.keylen);
    out_ready = 1'b0;
    offer_request(req);
    wait_result(cycles);
    check_latency(cycles, expected_latency(req.keylen));
    check_block("out_block", out_block, expected);
    // Second request offered while the result is blocked
    in_req   = other;
    in_valid = 1'b1;
    repeat (20)
    begin
      @(negedge clk);
      check_flag("out_valid", out_valid, 1'b1);
      check_flag("in_ready", in_ready, 1'b0);
      check_block("out_block", out_block, expected);
    end
    in_valid = 1'b0;
    out_ready = 1'b1;
    @(negedge clk);
    out_ready = 1'b0;
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("in_ready", in_ready, 1'b1);
    // Core stays idle on the last round when the blocked offer was never taken
    repeat (3)
    begin
      @(negedge clk);
      check_flag("in_ready", in_ready, 1'b1);
      check_round("round_idx", round_idx, `AES_ROUND_IDX_W'(`AES256_ROUNDS));
    end
  endtask

  // --------------------
  // Main sequence

  initial
  begin : main
    int errs;
    reset_n   = 1'b0;
    in_valid  = 1'b0;
    in_req    = '0;
    out_ready = 1'b0;
    lfsr_state = LFSR_SEED;
    for (int r = 0; r <= `AES256_ROUNDS; r++)
    begin
      round_keys[r].block = '0;
    end
    repeat (10)
    begin
      @(negedge clk);
    end
    reset_n = 1'b1;
    @(negedge clk);

    errs = error_count;
    test_after_reset();
    report_test("reset values", errs);

    errs = error_count;
    repeat (8)
    begin
      run_block(aes_pkg::KEY_128, 1'b0);
    end
    report_test("AES-128 random blocks", errs);

    errs = error_count;
    repeat (4)
    begin
      run_block(aes_pkg::KEY_256, 1'b0);
    end
    report_test("AES-256 random blocks", errs);

    errs = error_count;
    test_backpressure();
    report_test("output back-pressure", errs);

    // Key lengths alternate with the output always ready
    errs = error_count;
    out_ready = 1'b1;
    for (int i = 0; i < 6; i++)
    begin
      run_block((i % 2 == 0) ? aes_pkg::KEY_128 : aes_pkg::KEY_256, 1'b1);
    end
    out_ready = 1'b0;
    report_test("back-to-back mixed key lengths", errs);

    $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             test_count, fail_tests, check_count, error_count);
    if (error_count == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog on the clock
  initial
  begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== aes_encipher_core.f ====
+incdir+hdl
hdl/aes_pkg.sv
hdl/aes_sbox_word.sv
hdl/aes_round_datapath.sv
hdl/aes_encipher_ctrl.sv
hdl/aes_encipher_core.sv
dv/aes_encipher_sva.sv
dv/aes_encipher_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the AES encipher testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module aes_encipher_tb -f aes_encipher_core.f \
  --Mdir obj_dir -o aes_encipher_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/aes_encipher_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q -F -x '** PASS **' "$LOG"; then
  echo "Result: passed"
  exit 0
fi
echo "Result: failed"
exit 1
